//--- tb.f
mm_fixed_pkg.sv
mm_ctrl_pkg.sv
pe_mac.sv
systolic_array.sv
tile_ctrl.sv
block_accumulator.sv
matmul_tile.sv
matmul_assert.sv
tb_clk_gen.sv
tb_top.sv

//--- Makefile
VERILATOR       ?= verilator
TOP             ?= tb_top
FILELIST        ?= tb.f
OBJ_DIR         ?= obj_dir
VERILATOR_FLAGS ?= --binary --timing --assert --timescale 1ns/100ps -Wno-fatal
PASS_MSG        ?= Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	if echo "$$out" | grep -qxF "$(PASS_MSG)"; then \
		exit 0; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR)

//--- tb_top.sv
// ****************************************
// Testbench top for the matmul tile, runs
// random and saturating blocks back to back
// ****************************************
module tb_top import mm_fixed_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES = 16;
    localparam int BUSY_TMO     = 4;
    localparam int RESULT_TMO   = 20;

    logic          clk;
    logic          rst_n;
    logic          start;
    logic          op_valid;
    operand_beat_t op;
    logic          busy;
    logic          result_valid;
    c_block_t      result;

    operand_beat_t blk [8];
    int            seed = 32'h557b_c3d2;
    int            blocks_run = 0;
    int            pulses = 0;

    tb_clk_gen i_clk (.clk(clk));

    matmul_tile i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .op_valid     (op_valid),
        .op           (op),
        .busy         (busy),
        .result_valid (result_valid),
        .result       (result)
    );

    bind matmul_tile matmul_assert i_assert (
        .clk          (clk),
        .rst_n        (rst_n),
        .op_valid     (op_valid),
        .op           (op),
        .busy         (busy),
        .result_valid (result_valid),
        .result       (result)
    );

    // Independent count of result pulses
    always @(posedge clk) begin
        if (rst_n && result_valid) begin
            pulses <= pulses + 1;
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic timeout(input string name, input string what);
        $display("Timeout in %s: %s never came", name, what);
        $display("Simulation failed");
        $fatal(1, "Run stopped after a timeout");
    endtask

    // Random operand within about +-8.0
    function automatic q88_t rand_q88();
        int r;
        r = $random(seed);
        return q88_t'(r >>> 20);
    endfunction

    function automatic operand_beat_t rand_beat();
        return '{a0: rand_q88(), a1: rand_q88(), b0: rand_q88(), b1: rand_q88()};
    endfunction

    task automatic fill_random();
        for (int k = 0; k < 8; k++) begin
            blk[k] = rand_beat();
        end
    endtask

    // Chunk 0 clamps high, chunk 1 clamps low for row 0 and high for row 1
    task automatic fill_chunk_sat();
        for (int k = 0; k < 8; k++) begin
            blk[k] = '0;
        end
        blk[0] = '{a0: 16'sh7FFF, a1: 16'sh7FFF, b0: 16'sh7FFF, b1: 16'sh7FFE};
        blk[1] = blk[0];
        blk[2] = '{a0: 16'sh7FFF, a1: 16'sh8000, b0: 16'sh8000, b1: 16'sh8001};
        blk[3] = blk[2];
    endtask

    // No chunk clamps, but the block total runs past both ends
    task automatic fill_sum_sat();
        for (int k = 0; k < 8; k++) begin
            blk[k] = '{a0: 16'sh0800, a1: 16'sh0800, b0: 16'sh0600, b1: 16'shFA00};
        end
    endtask

    task automatic run_block(input string name, input bit gaps, input bit extra_start);
        int cycles;
        int gap_len;
        start = 1'b1;
        next_cycle();
        start = 1'b0;
        cycles = 0;
        while (!busy) begin
            if (cycles == BUSY_TMO) begin
                timeout(name, "busy");
            end else begin
                cycles++;
                next_cycle();
            end
        end
        for (int k = 0; k < 8; k++) begin
            gap_len = gaps ? ($random(seed) & 32'h3) : 0;
            // Bubbles carry junk operands with op_valid low
            repeat (gap_len) begin
                op_valid = 1'b0;
                op       = rand_beat();
                start    = 1'b0;
                next_cycle();
            end
            op_valid = 1'b1;
            op       = blk[k];
            start    = extra_start && (k == 3);
            next_cycle();
        end
        op_valid = 1'b0;
        op       = '0;
        start    = 1'b0;
        cycles = 0;
        while (!result_valid) begin
            if (cycles == RESULT_TMO) begin
                timeout(name, "result_valid");
            end else begin
                cycles++;
                next_cycle();
            end
        end
        blocks_run++;
    endtask

    initial begin
        rst_n    = 1'b0;
        start    = 1'b0;
        op_valid = 1'b0;
        op       = '0;
        repeat (RESET_CYCLES) next_cycle();
        rst_n = 1'b1;
        repeat (3) next_cycle();

        fill_random();
        run_block("random_plain", 1'b0, 1'b0);
        repeat (2) next_cycle();
        fill_random();
        run_block("random_gaps", 1'b1, 1'b1);
        // Same operands again with other gaps, starting in the result cycle
        run_block("random_gaps_repeat", 1'b1, 1'b0);
        next_cycle();
        fill_chunk_sat();
        run_block("sat_chunk", 1'b1, 1'b0);
        fill_sum_sat();
        run_block("sat_total", 1'b0, 1'b1);
        fill_random();
        run_block("back_to_back_a", 1'b0, 1'b0);
        fill_random();
        run_block("back_to_back_b", 1'b1, 1'b0);

        repeat (8) next_cycle();
        if (pulses != blocks_run) begin
            $display("Mismatch result_count: expected %0d, actual %0d", blocks_run, pulses);
            $display("Simulation failed");
            $fatal(1, "Wrong number of result pulses");
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

//--- tb_clk_gen.sv
// ****************************************
// Free-running testbench clock, 40 ns period
// ****************************************
module tb_clk_gen (
    output logic clk
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

endmodule

//--- matmul_assert.sv
// ****************************************
// Checker bound to the matmul tile, a shadow
// model feeds the concurrent assertions
// ****************************************
module matmul_assert import mm_fixed_pkg::*; (
    input logic          clk,
    input logic          rst_n,
    input logic          op_valid,
    input operand_beat_t op,
    input logic          busy,
    input logic          result_valid,
    input c_block_t      result
);

    timeunit 1ns;
    timeprecision 100ps;

    longint   chunk_sum [4];
    longint   block_sum [4];
    q88_t     expected [4];
    c_block_t held;
    int       beat_cnt;
    int       edge_cnt;
    int       block_no;
    logic     pending;
    logic     rv_due;

    function automatic longint clamp_q88(input longint v);
        if (v > 32767) begin
            return 32767;
        end
        if (v < -32768) begin
            return -32768;
        end
        return v;
    endfunction

    // Full product brought back to Q8.8 by dropping the low fraction bits
    function automatic longint scaled_product(input q88_t x, input q88_t y);
        longint p;
        p = longint'(x) * longint'(y);
        return p >>> FRAC_W;
    endfunction

    // Element order c00, c01, c10, c11
    function automatic longint element_product(input operand_beat_t b, input int idx);
        case (idx)
            0: return scaled_product(b.a0, b.b0);
            1: return scaled_product(b.a0, b.b1);
            2: return scaled_product(b.a1, b.b0);
            default: return scaled_product(b.a1, b.b1);
        endcase
    endfunction

    // Result is due in the cycle after the third edge past the 8th beat
    assign rv_due = pending && (edge_cnt == 3);

    always @(posedge clk) begin : shadow
        longint prod;
        longint csum;
        longint ctot;
        held <= result;
        if (!rst_n) begin
            beat_cnt <= 0;
            edge_cnt <= 0;
            block_no <= 0;
            pending  <= 1'b0;
            for (int i = 0; i < 4; i++) begin
                chunk_sum[i] <= 0;
                block_sum[i] <= 0;
                expected[i]  <= '0;
            end
        end else begin
            if (pending) begin
                edge_cnt <= edge_cnt + 1;
                if (result_valid) begin
                    pending  <= 1'b0;
                    block_no <= block_no + 1;
                end
            end
            if (busy && op_valid && !pending) begin
                for (int i = 0; i < 4; i++) begin
                    prod = element_product(op, i);
                    csum = (beat_cnt % 2 == 0) ? prod : chunk_sum[i] + prod;
                    chunk_sum[i] <= csum;
                    // Chunk clamps on its second beat before joining the block total
                    ctot = block_sum[i] + clamp_q88(csum);
                    if (beat_cnt == 7) begin
                        expected[i]  <= q88_t'(clamp_q88(ctot));
                        block_sum[i] <= 0;
                    end else if (beat_cnt % 2 == 1) begin
                        block_sum[i] <= ctot;
                    end
                end
                if (beat_cnt == 7) begin
                    beat_cnt <= 0;
                    edge_cnt <= 0;
                    pending  <= 1'b1;
                end else begin
                    beat_cnt <= beat_cnt + 1;
                end
            end
        end
    end

    a_c00: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid |-> (result.c00 == expected[0]))
        else $error("Mismatch result_c00 block %0d: expected %h, actual %h",
                    $sampled(block_no), $sampled(expected[0]), $sampled(result.c00));

    a_c01: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid |-> (result.c01 == expected[1]))
        else $error("Mismatch result_c01 block %0d: expected %h, actual %h",
                    $sampled(block_no), $sampled(expected[1]), $sampled(result.c01));

    a_c10: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid |-> (result.c10 == expected[2]))
        else $error("Mismatch result_c10 block %0d: expected %h, actual %h",
                    $sampled(block_no), $sampled(expected[2]), $sampled(result.c10));

    a_c11: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid |-> (result.c11 == expected[3]))
        else $error("Mismatch result_c11 block %0d: expected %h, actual %h",
                    $sampled(block_no), $sampled(expected[3]), $sampled(result.c11));

    a_rv_due: assert property (@(posedge clk) disable iff (!rst_n)
        rv_due |-> result_valid)
        else $error("Mismatch result_timing block %0d: expected result_valid 1, actual %b",
                    $sampled(block_no), $sampled(result_valid));

    a_rv_only: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid |-> rv_due)
        else $error("Mismatch result_timing block %0d: expected result_valid 0, actual %b",
                    $sampled(block_no), $sampled(result_valid));

    a_busy_fall: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid |-> !busy)
        else $error("Mismatch busy_fall block %0d: expected busy 0, actual %b",
                    $sampled(block_no), $sampled(busy));

    a_busy_drain: assert property (@(posedge clk) disable iff (!rst_n)
        (pending && (edge_cnt < 3)) |-> busy)
        else $error("Mismatch busy_drain block %0d: expected busy 1, actual %b",
                    $sampled(block_no), $sampled(busy));

    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !result_valid |-> (result == held))
        else $error("Mismatch result_hold block %0d: expected %h, actual %h",
                    $sampled(block_no), $sampled(held), $sampled(result));

    // Outputs right after reset is released
    a_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> (!busy && !result_valid && (result == '0)))
        else $error("Mismatch reset_state: expected busy 0 result_valid 0 result 0, %s %b %b %h",
                    "actual", $sampled(busy), $sampled(result_valid), $sampled(result));

endmodule

//--- matmul_tile.sv
// ****************************************
// Matmul tile top, one 2x2 block of C
// from eight streamed operand beats
// ****************************************
module matmul_tile import mm_fixed_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          start,
    input  logic          op_valid,
    input  operand_beat_t op,
    output logic          busy,
    output logic          result_valid,
    output c_block_t      result
);

    logic     beat_valid;
    logic     beat_first;
    logic     beat_last;
    c_block_t chunk;
    logic     chunk_valid;

    tile_ctrl i_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .op_valid     (op_valid),
        .result_valid (result_valid),
        .busy         (busy),
        .beat_valid   (beat_valid),
        .beat_first   (beat_first),
        .beat_last    (beat_last)
    );

    // Operand values go straight in, only the tags come from the controller
    systolic_array i_array (
        .clk         (clk),
        .rst_n       (rst_n),
        .beat        (op),
        .beat_valid  (beat_valid),
        .beat_first  (beat_first),
        .beat_last   (beat_last),
        .chunk       (chunk),
        .chunk_valid (chunk_valid)
    );

    block_accumulator i_accum (
        .clk          (clk),
        .rst_n        (rst_n),
        .chunk        (chunk),
        .chunk_valid  (chunk_valid),
        .result       (result),
        .result_valid (result_valid)
    );

endmodule

//--- block_accumulator.sv
// ****************************************
// Sums the chunk results of one block and
// saturates the total into the result
// ****************************************
module block_accumulator
    import mm_fixed_pkg::*;
    import mm_ctrl_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  c_block_t chunk,
    input  logic     chunk_valid,
    output c_block_t result,
    output logic     result_valid
);

    logic signed [ACC_W-1:0] acc [4];
    logic signed [ACC_W-1:0] total [4];
    q88_t                    chunk_w [4];
    logic [CHUNK_CNT_W-1:0]  chunk_cnt;

    assign chunk_w[0] = chunk.c00;
    assign chunk_w[1] = chunk.c01;
    assign chunk_w[2] = chunk.c10;
    assign chunk_w[3] = chunk.c11;

    // Running sum including the chunk on the input
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            total[i] = acc[i] + ACC_W'(chunk_w[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 4; i++) begin
                acc[i] <= '0;
            end
            chunk_cnt    <= '0;
            result       <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= 1'b0;
            if (chunk_valid) begin
                if (chunk_cnt == CHUNK_CNT_W'(NUM_CHUNKS - 1)) begin
                    result <= '{c00: sat_q88(PSUM_W'(total[0])),
                                c01: sat_q88(PSUM_W'(total[1])),
                                c10: sat_q88(PSUM_W'(total[2])),
                                c11: sat_q88(PSUM_W'(total[3]))};
                    result_valid <= 1'b1;
                    chunk_cnt    <= '0;
                    // Start the next block from zero
                    for (int i = 0; i < 4; i++) begin
                        acc[i] <= '0;
                    end
                end else begin
                    chunk_cnt <= chunk_cnt + 1'b1;
                    for (int i = 0; i < 4; i++) begin
                        acc[i] <= total[i];
                    end
                end
            end
        end
    end

endmodule

//--- tile_ctrl.sv
// ****************************************
// Tile controller, takes start, counts the
// operand beats and tags chunk boundaries
// ****************************************
module tile_ctrl import mm_ctrl_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    input  logic op_valid,
    input  logic result_valid,
    output logic busy,
    output logic beat_valid,
    output logic beat_first,
    output logic beat_last
);

    tile_state_e           state;
    logic [BEAT_CNT_W-1:0] beat_cnt;
    logic [BEAT_CNT_W-1:0] beat_pos;

    // Position of the current beat inside its chunk
    assign beat_pos = beat_cnt % BEAT_CNT_W'(BLOCK_SIZE);

    assign beat_valid = (state == STREAM) && op_valid;
    assign beat_first = beat_valid && (beat_pos == '0);
    assign beat_last  = beat_valid && (beat_pos == BEAT_CNT_W'(BLOCK_SIZE - 1));

    // Drops together with the result pulse, not one cycle after it
    assign busy = (state == STREAM) || ((state == DRAIN) && !result_valid);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state    <= STREAM;
                        beat_cnt <= '0;
                    end
                end
                STREAM: begin
                    if (op_valid) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        // Counter reaches K_DIM with this beat
                        if (beat_cnt == BEAT_CNT_W'(K_DIM - 1)) begin
                            state <= DRAIN;
                        end
                    end
                end
                DRAIN: begin
                    // busy is already low here so a new start is taken
                    if (result_valid) begin
                        state    <= start ? STREAM : IDLE;
                        beat_cnt <= '0;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

//--- systolic_array.sv
// ****************************************
// 2x2 output-stationary array, A flows
// right and B flows down with input skew
// ****************************************
module systolic_array import mm_fixed_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  operand_beat_t beat,
    input  logic          beat_valid,
    input  logic          beat_first,
    input  logic          beat_last,
    output c_block_t      chunk,
    output logic          chunk_valid
);

    pe_flow_t a0_in;
    pe_flow_t b0_in;
    pe_flow_t a1_now;
    pe_flow_t b1_now;
    pe_flow_t a1_skew;
    pe_flow_t b1_skew;
    pe_flow_t a_00_01;
    pe_flow_t a_10_11;
    pe_flow_t b_00_10;
    pe_flow_t b_01_11;
    q88_t     c00_pe;
    q88_t     c01_pe;
    q88_t     c10_pe;
    q88_t     c11_pe;
    q88_t     c00_d1;
    q88_t     c00_d2;
    q88_t     c01_d1;
    q88_t     c10_d1;
    logic     done11;

    assign a0_in  = '{value: beat.a0, valid: beat_valid, first: beat_first, last: beat_last};
    assign b0_in  = '{value: beat.b0, valid: beat_valid, first: beat_first, last: beat_last};
    assign a1_now = '{value: beat.a1, valid: beat_valid, first: beat_first, last: beat_last};
    assign b1_now = '{value: beat.b1, valid: beat_valid, first: beat_first, last: beat_last};

    // Row 1 of A and column 1 of B enter one cycle late
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            a1_skew <= '0;
            b1_skew <= '0;
        end else begin
            a1_skew <= a1_now;
            b1_skew <= b1_now;
        end
    end

    pe_mac i_pe00 (.clk(clk), .rst_n(rst_n), .a_in(a0_in), .b_in(b0_in),
                   .a_out(a_00_01), .b_out(b_00_10), .c_out(c00_pe), .done());
    pe_mac i_pe01 (.clk(clk), .rst_n(rst_n), .a_in(a_00_01), .b_in(b1_skew),
                   .a_out(), .b_out(b_01_11), .c_out(c01_pe), .done());
    pe_mac i_pe10 (.clk(clk), .rst_n(rst_n), .a_in(a1_skew), .b_in(b_00_10),
                   .a_out(a_10_11), .b_out(), .c_out(c10_pe), .done());
    pe_mac i_pe11 (.clk(clk), .rst_n(rst_n), .a_in(a_10_11), .b_in(b_01_11),
                   .a_out(), .b_out(), .c_out(c11_pe), .done(done11));

    // Early PEs finish first, delay them so all four line up with PE(1,1)
    // otherwise the next chunk would overwrite c00 while chunk_valid is high
    always_ff @(posedge clk) begin
        c00_d1 <= c00_pe;
        c00_d2 <= c00_d1;
        c01_d1 <= c01_pe;
        c10_d1 <= c10_pe;
    end

    assign chunk       = '{c00: c00_d2, c01: c01_d1, c10: c10_d1, c11: c11_pe};
    assign chunk_valid = done11;

endmodule

//--- pe_mac.sv
// ****************************************
// Systolic processing element, MAC over
// one chunk, forwards operands onward
// ****************************************
module pe_mac import mm_fixed_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  pe_flow_t a_in,
    input  pe_flow_t b_in,
    output pe_flow_t a_out,
    output pe_flow_t b_out,
    output q88_t     c_out,
    output logic     done
);

    logic signed [PROD_W-1:0] prod;
    logic signed [PSUM_W-1:0] prod_q;
    logic signed [PSUM_W-1:0] sum;
    logic signed [PSUM_W-1:0] sum_next;
    logic                     beat_ok;

    // Both operands belong to the same beat, a bubble has valid low
    assign beat_ok = a_in.valid & b_in.valid;

    assign prod   = a_in.value * b_in.value;
    // Truncate back to Q8.8 scale, arithmetic shift keeps the sign
    assign prod_q = PSUM_W'(prod >>> FRAC_W);

    assign sum_next = a_in.first ? prod_q : sum + prod_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            a_out <= '0;
            b_out <= '0;
            done  <= 1'b0;
        end else begin
            a_out <= a_in;
            b_out <= b_in;
            done  <= beat_ok & a_in.last;
        end
    end

    always_ff @(posedge clk) begin
        if (beat_ok) begin
            sum <= sum_next;
        end
        // Chunk result held until the next last beat
        if (beat_ok && a_in.last) begin
            c_out <= sat_q88(sum_next);
        end
    end

endmodule

//--- mm_ctrl_pkg.sv
// ****************************************
// Sequencing constants and controller
// states for the matmul tile
// ****************************************
package mm_ctrl_pkg;

    // Array edge length and inner dimension of one block
    localparam int BLOCK_SIZE = 2;
    localparam int K_DIM      = 8;

    // One chunk is BLOCK_SIZE beats
    localparam int NUM_CHUNKS = K_DIM / BLOCK_SIZE;

    // Beat counter must be able to hold K_DIM itself
    localparam int BEAT_CNT_W  = $clog2(K_DIM + 1);
    localparam int CHUNK_CNT_W = $clog2(NUM_CHUNKS);

    typedef enum logic [1:0] {
        IDLE,
        STREAM,
        DRAIN
    } tile_state_e;

endpackage

//--- mm_fixed_pkg.sv
// ****************************************
// Q8.8 number format shared by the tile
// Widths, datapath structs and saturation
// ****************************************
package mm_fixed_pkg;

    localparam int DATA_W = 16;
    localparam int FRAC_W = 8;

    // Full product of two words, and the PE sum after the Q8.8 rescale
    // One spare bit so two extreme products add without wrapping
    localparam int PROD_W = 2 * DATA_W;
    localparam int PSUM_W = PROD_W - FRAC_W + 1;

    // Guard bits for the four chunk sums plus margin
    localparam int ACC_W = DATA_W + $clog2(4) + 2;

    typedef logic signed [DATA_W-1:0] q88_t;

    localparam q88_t Q88_MAX = 16'sh7FFF;
    localparam q88_t Q88_MIN = 16'sh8000;

    typedef struct packed {
        q88_t a0;
        q88_t a1;
        q88_t b0;
        q88_t b1;
    } operand_beat_t;

    // One operand hop between neighbouring PEs, tags ride along
    typedef struct packed {
        q88_t value;
        logic valid;
        logic first;
        logic last;
    } pe_flow_t;

    typedef struct packed {
        q88_t c00;
        q88_t c01;
        q88_t c10;
        q88_t c11;
    } c_block_t;

    // Clamp a wide signed value into the Q8.8 range
    function automatic q88_t sat_q88(input logic signed [PSUM_W-1:0] val);
        if (val > PSUM_W'(Q88_MAX)) begin
            return Q88_MAX;
        end
        if (val < PSUM_W'(Q88_MIN)) begin
            return Q88_MIN;
        end
        return val[DATA_W-1:0];
    endfunction

endpackage
